// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = ifront_tb
FILELIST  = ifront.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/ifront_tests.svh ====
`ifndef IFRONT_TESTS_SVH
`define IFRONT_TESTS_SVH

// ------------------------------------------------------------
// reference decode with one flag row per opcode
// ------------------------------------------------------------
function automatic void expect_decode(input ifront_pkg::instr_t w);
    ifront_pkg::opc_t opc;
    ifront_pkg::imm_t imm;
    logic [5:0]       flags;  // imm_en, sgn_en, tgt_we, has_tgt, has_src, has_cc
    logic             has_tgt;
    logic             has_src;
    logic             has_cc;
    opc = ifront_pkg::opc_t'(w[`IFRONT_OPC_HI:`IFRONT_OPC_LO]);
    imm = w[`IFRONT_IMM_HI:`IFRONT_IMM_LO];
    exp_illegal = (w[`IFRONT_OPC_HI:`IFRONT_OPC_LO] > 5'd21);
    case (opc)
        ifront_pkg::MOV, ifront_pkg::AND, ifront_pkg::OR, ifront_pkg::XOR,
        ifront_pkg::SHL, ifront_pkg::LD:                    flags = 6'b001110;
        ifront_pkg::ADD, ifront_pkg::SUB, ifront_pkg::SHR:  flags = 6'b011110;
        ifront_pkg::CMP:                                    flags = 6'b010110;
        ifront_pkg::ST:                                     flags = 6'b000110;
        ifront_pkg::MOVI, ifront_pkg::ADDI, ifront_pkg::SUBI,
        ifront_pkg::LUI:                                    flags = 6'b101100;
        ifront_pkg::ADDIS:                                  flags = 6'b111100;
        ifront_pkg::CMPI, ifront_pkg::STI:                  flags = 6'b100100;
        ifront_pkg::CMPIS:                                  flags = 6'b110100;
        ifront_pkg::JCC:                                    flags = 6'b000011;
        ifront_pkg::BCCIS:                                  flags = 6'b110001;
        default:                                            flags = 6'b000000;  // NOP and undefined codes
    endcase
    {exp_imm_en, exp_sgn_en, exp_tgt_we, has_tgt, has_src, has_cc} = flags;
    exp_opc = exp_illegal ? ifront_pkg::NOP : opc;
    if (!exp_imm_en) begin
        exp_imm_val = '0;
    end else if (opc == ifront_pkg::LUI) begin
        exp_imm_val = {imm, 8'h00};
    end else if (exp_sgn_en) begin
        exp_imm_val = {{8{imm[7]}}, imm};
    end else begin
        exp_imm_val = {8'h00, imm};
    end
    exp_tgt = has_tgt ? w[`IFRONT_TGT_HI:`IFRONT_TGT_LO] : '0;
    exp_cc  = has_cc ? w[`IFRONT_TGT_HI:`IFRONT_TGT_LO] : '0;
    exp_src = has_src ? w[`IFRONT_SRC_HI:`IFRONT_SRC_LO] : '0;
endfunction

task automatic collect_words(input int words);
    int target;
    target = got_words + words;
    while (got_words < target) begin
        step_cycle(1'b1, 1'b0, '0);
    end
endtask

// ------------------------------------------------------------
// directed tests
// ------------------------------------------------------------
task automatic reset_and_first_word();
    @(negedge iw_clk);
    check_bit("imem_req", imem_req, 1'b0);
    check_bit("dec_valid", dec_valid, 1'b0);
    repeat (3) @(posedge iw_clk);
    #2;
    iw_rst = 1'b0;
    @(negedge iw_clk);
    check_bit("imem_req", imem_req, 1'b0);  // fetch FSM still idle
    check_bit("dec_valid", dec_valid, 1'b0);
    for (int c = 1; c <= 3; c++) begin
        step_cycle(1'b1, 1'b0, '0);
        check_bit("dec_valid", dec_valid, 1'b0);
        if (c == 1) begin
            check_bit("imem_req", imem_req, 1'b1);
            check_addr("imem_addr", imem_addr, '0);
        end
    end
    step_cycle(1'b1, 1'b0, '0);
    check_bit("dec_valid", dec_valid, 1'b1);  // pc 0 arrives four cycles after reset
endtask

task automatic decode_every_opcode();
    collect_words(63);  // the first 64 words carry every opcode value
endtask

task automatic stream_at_full_rate();
    for (int i = 0; i < 64; i++) begin
        step_cycle(1'b1, 1'b0, '0);
        check_bit("dec_valid", dec_valid, 1'b1);  // one word per cycle once flowing
    end
endtask

task automatic random_backpressure(input int words);
    int   target;
    int   run_left;
    logic level;
    target   = got_words + words;
    run_left = 0;
    level    = 1'b1;
    while (got_words < target) begin
        if (run_left == 0) begin
            level    = !level;
            run_left = level ? 1 + $urandom % 4 : 1 + $urandom % 16;
        end
        step_cycle(level, 1'b0, '0);
        run_left--;
    end
endtask

task automatic redirect_mid_stream();
    collect_words(3);
    step_cycle(1'b1, 1'b1, 12'hffd);  // runs across the top of memory
    collect_words(16);
endtask

task automatic flush_full_queue();
    repeat (12) begin
        step_cycle(1'b0, 1'b0, '0);
    end
    check_bit("imem_req", imem_req, 1'b0);  // a full queue has stalled fetch
    step_cycle(1'b0, 1'b1, 12'h123);
    step_cycle(1'b1, 1'b1, 12'h456);
    step_cycle(1'b1, 1'b1, 12'h7a0);
    collect_words(16);
endtask

`endif

// ==== dv/ifront_tb.sv ====
`timescale 1ns/1ps

`include "ifront_settings.svh"

module ifront_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int SEED            = 4128;
    localparam int MEM_WORDS       = 1 << `IFRONT_ADDR_W;
    localparam int TOTAL_WORDS     = 243;  // decoded words collected over all tests
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_WORDS + 200;

    logic                 iw_clk = 1'b0;
    logic                 iw_rst;
    logic                 imem_req;
    ifront_pkg::addr_t    imem_addr;
    ifront_pkg::instr_t   imem_data;
    logic                 redirect;
    ifront_pkg::addr_t    redirect_pc;
    logic                 dec_valid;
    logic                 dec_ready;
    ifront_pkg::addr_t    dec_pc;
    ifront_pkg::instr_t   dec_instr;
    ifront_pkg::opc_t     dec_opc;
    logic                 dec_sgn_en;
    logic                 dec_imm_en;
    ifront_pkg::word_t    dec_imm_val;
    ifront_pkg::cc_t      dec_cc;
    ifront_pkg::reg_idx_t dec_tgt;
    logic                 dec_tgt_we;
    ifront_pkg::reg_idx_t dec_src;
    logic                 dec_illegal;

    ifront_pkg::instr_t   mem [MEM_WORDS];

    ifront_pkg::addr_t    exp_pc;      // pc of the next word the output must show
    int                   got_words;
    logic                 held;        // a valid word was stalled last cycle

    ifront_pkg::opc_t     exp_opc;
    logic                 exp_sgn_en;
    logic                 exp_imm_en;
    ifront_pkg::word_t    exp_imm_val;
    ifront_pkg::cc_t      exp_cc;
    ifront_pkg::reg_idx_t exp_tgt;
    logic                 exp_tgt_we;
    ifront_pkg::reg_idx_t exp_src;
    logic                 exp_illegal;

    always #(CLK_PERIOD / 2) iw_clk = ~iw_clk;

    ifront_top dut0 (.*);

    `include "ifront_tests.svh"

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input ifront_pkg::instr_t got,
                              input ifront_pkg::instr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input ifront_pkg::addr_t got,
                              input ifront_pkg::addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_opc(input string name, input ifront_pkg::opc_t got,
                             input ifront_pkg::opc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input ifront_pkg::reg_idx_t got,
                             input ifront_pkg::reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_imm(input string name, input ifront_pkg::word_t got,
                             input ifront_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------
    // output scoreboard and cycle stepping
    // ------------------------------------------------------------
    task automatic compare_output();
        ifront_pkg::instr_t w;
        w = mem[exp_pc];
        expect_decode(w);
        check_addr("dec_pc", dec_pc, exp_pc);
        check_word("dec_instr", dec_instr, w);
        check_opc("dec_opc", dec_opc, exp_opc);
        check_bit("dec_sgn_en", dec_sgn_en, exp_sgn_en);
        check_bit("dec_imm_en", dec_imm_en, exp_imm_en);
        check_imm("dec_imm_val", dec_imm_val, exp_imm_val);
        check_reg("dec_cc", dec_cc, exp_cc);
        check_reg("dec_tgt", dec_tgt, exp_tgt);
        check_bit("dec_tgt_we", dec_tgt_we, exp_tgt_we);
        check_reg("dec_src", dec_src, exp_src);
        check_bit("dec_illegal", dec_illegal, exp_illegal);
    endtask

    task automatic step_cycle(input logic rdy, input logic redir, input ifront_pkg::addr_t rpc);
        @(posedge iw_clk);
        #2;
        dec_ready   = rdy;
        redirect    = redir;
        redirect_pc = rpc;
        @(negedge iw_clk);
        if (held) begin  // a stalled word must not drop out
            check_bit("dec_valid", dec_valid, 1'b1);
        end
        if (dec_valid) begin
            compare_output();  // stalled or not, the word shown must be the next one in order
        end
        if (redir) begin
            exp_pc = rpc;  // older words are flushed at the next edge
            held   = 1'b0;
        end else begin
            if (dec_valid && dec_ready) begin
                exp_pc = exp_pc + 1'b1;
                got_words++;
            end
            held = dec_valid && !dec_ready;
        end
    endtask

    task automatic fill_memory();
        logic [31:0] rnd;
        for (int a = 0; a < MEM_WORDS; a++) begin
            rnd = $urandom;
            mem[a[`IFRONT_ADDR_W-1:0]] = rnd[15:0];
            if (a < 64) begin
                mem[a[`IFRONT_ADDR_W-1:0]][`IFRONT_OPC_HI:`IFRONT_OPC_LO] = a[4:0];  // all codes
            end
        end
    endtask

    // instruction memory answers one cycle after each request
    initial begin : imem_model
        logic              rd_en;
        ifront_pkg::addr_t rd_addr;
        imem_data = '0;
        forever begin
            @(negedge iw_clk);
            rd_en   = imem_req;
            rd_addr = imem_addr;
            @(posedge iw_clk);
            #2;
            if (rd_en) begin
                imem_data = mem[rd_addr];
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("the run timed out before all decoded words arrived");
    end

    initial begin : main
        iw_rst      = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        dec_ready   = 1'b0;
        exp_pc      = '0;
        got_words   = 0;
        held        = 1'b0;
        void'($urandom(SEED));
        fill_memory();
        reset_and_first_word();
        decode_every_opcode();
        stream_at_full_rate();
        random_backpressure(80);
        redirect_mid_stream();
        flush_full_queue();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

`include "ifront_settings.svh"

module decode_stage (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    input  logic                 flush,
    input  logic                 q_valid,
    output logic                 q_ready,
    input  ifront_pkg::addr_t    q_addr,
    input  ifront_pkg::instr_t   q_instr,
    output logic                 dec_valid,
    input  logic                 dec_ready,
    output ifront_pkg::addr_t    dec_pc,
    output ifront_pkg::instr_t   dec_instr,
    output ifront_pkg::opc_t     dec_opc,
    output logic                 dec_sgn_en,
    output logic                 dec_imm_en,
    output ifront_pkg::word_t    dec_imm_val,
    output ifront_pkg::cc_t      dec_cc,
    output ifront_pkg::reg_idx_t dec_tgt,
    output logic                 dec_tgt_we,
    output ifront_pkg::reg_idx_t dec_src,
    output logic                 dec_illegal
);
    localparam int IMM_W  = $bits(ifront_pkg::imm_t);
    localparam int WORD_W = $bits(ifront_pkg::word_t);

    ifront_pkg::opc_t     opc;
    ifront_pkg::imm_t     imm;
    logic                 legal;
    logic                 imm_en;
    logic                 sgn_en;
    logic                 tgt_we;
    logic                 has_tgt;
    logic                 has_src;
    logic                 has_cc;
    ifront_pkg::opc_t     opc_d;
    ifront_pkg::word_t    imm_val_d;
    ifront_pkg::cc_t      cc_d;
    ifront_pkg::reg_idx_t tgt_d;
    ifront_pkg::reg_idx_t src_d;
    logic                 load;

    assign opc   = ifront_pkg::opc_t'(q_instr[`IFRONT_OPC_HI:`IFRONT_OPC_LO]);
    assign imm   = q_instr[`IFRONT_IMM_HI:`IFRONT_IMM_LO];
    assign legal = (opc <= ifront_pkg::LUI);

    // ------------------------------------------------------------
    // opcode classes, undefined codes fall outside every list
    // ------------------------------------------------------------
    assign imm_en = opc inside {ifront_pkg::MOVI,  ifront_pkg::ADDI,  ifront_pkg::SUBI,
                                ifront_pkg::ADDIS, ifront_pkg::CMPI,  ifront_pkg::CMPIS,
                                ifront_pkg::STI,   ifront_pkg::BCCIS, ifront_pkg::LUI};

    assign sgn_en = opc inside {ifront_pkg::ADD,   ifront_pkg::SUB,   ifront_pkg::SHR,
                                ifront_pkg::CMP,   ifront_pkg::ADDIS, ifront_pkg::CMPIS,
                                ifront_pkg::BCCIS};

    assign tgt_we = opc inside {ifront_pkg::MOV,   ifront_pkg::ADD,   ifront_pkg::SUB,
                                ifront_pkg::AND,   ifront_pkg::OR,    ifront_pkg::XOR,
                                ifront_pkg::SHL,   ifront_pkg::SHR,   ifront_pkg::LD,
                                ifront_pkg::MOVI,  ifront_pkg::ADDI,  ifront_pkg::SUBI,
                                ifront_pkg::ADDIS, ifront_pkg::LUI};

    assign has_tgt = tgt_we ||
                     (opc inside {ifront_pkg::CMP, ifront_pkg::CMPI, ifront_pkg::CMPIS,
                                  ifront_pkg::ST,  ifront_pkg::STI});

    assign has_src = opc inside {[ifront_pkg::MOV:ifront_pkg::ST], ifront_pkg::JCC};
    assign has_cc  = opc inside {ifront_pkg::JCC, ifront_pkg::BCCIS};

    // ------------------------------------------------------------
    // field masking and immediate extension
    // ------------------------------------------------------------
    always_comb begin
        if (!imm_en) begin
            imm_val_d = '0;
        end else if (opc == ifront_pkg::LUI) begin
            imm_val_d = {imm, {(WORD_W - IMM_W){1'b0}}};  // upper byte
        end else if (sgn_en) begin
            imm_val_d = {{(WORD_W - IMM_W){imm[IMM_W-1]}}, imm};
        end else begin
            imm_val_d = {{(WORD_W - IMM_W){1'b0}}, imm};
        end
    end

    assign opc_d = legal ? opc : ifront_pkg::NOP;
    assign cc_d  = has_cc ? q_instr[`IFRONT_TGT_HI:`IFRONT_TGT_LO] : '0;
    assign tgt_d = has_tgt ? q_instr[`IFRONT_TGT_HI:`IFRONT_TGT_LO] : '0;
    assign src_d = has_src ? q_instr[`IFRONT_SRC_HI:`IFRONT_SRC_LO] : '0;

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    assign q_ready = !dec_valid || dec_ready;  // register empty or draining
    assign load    = q_valid && q_ready;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (q_ready) begin
            dec_valid <= q_valid;
        end
    end

    always_ff @(posedge iw_clk) begin
        if (load) begin
            dec_pc      <= q_addr;
            dec_instr   <= q_instr;
            dec_opc     <= opc_d;
            dec_sgn_en  <= sgn_en;
            dec_imm_en  <= imm_en;
            dec_imm_val <= imm_val_d;
            dec_cc      <= cc_d;
            dec_tgt     <= tgt_d;
            dec_tgt_we  <= tgt_we;
            dec_src     <= src_d;
            dec_illegal <= !legal;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic               redirect,
    input  ifront_pkg::addr_t  redirect_pc,
    output logic               imem_req,
    output ifront_pkg::addr_t  imem_addr,
    input  ifront_pkg::instr_t imem_data,
    output logic               f_valid,
    input  logic               f_ready,
    output ifront_pkg::addr_t  f_addr,
    output ifront_pkg::instr_t f_instr
);
    ifront_pkg::fetch_state_e state;
    ifront_pkg::addr_t        pc;          // next address to request
    logic                     pending;     // request issued last cycle, data arrives now
    ifront_pkg::addr_t        pend_addr;
    logic                     hold_valid;
    ifront_pkg::addr_t        hold_addr;
    ifront_pkg::instr_t       hold_instr;
    logic                     slot_free;
    logic                     capture;

    // pending and hold_valid are never set together, a request is only made
    // once the word in front of it has left
    assign f_valid = hold_valid | pending;
    assign f_addr  = hold_valid ? hold_addr : pend_addr;
    assign f_instr = hold_valid ? hold_instr : imem_data;  // memory data passes straight through

    assign slot_free = !f_valid || f_ready;  // output slot empty on the next cycle
    assign imem_req  = (state == ifront_pkg::RUN) && slot_free && !redirect;
    assign imem_addr = pc;

    assign capture = pending && !f_ready;  // returning word stalls, park it

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state      <= ifront_pkg::IDLE;
            pc         <= '0;
            pending    <= 1'b0;
            hold_valid <= 1'b0;
        end else if (redirect) begin
            state      <= ifront_pkg::RUN;
            pc         <= redirect_pc;
            pending    <= 1'b0;  // data coming back this cycle is dropped
            hold_valid <= 1'b0;
        end else begin
            if (state == ifront_pkg::IDLE) begin
                state <= ifront_pkg::RUN;
            end
            pending <= imem_req;
            if (imem_req) begin
                pc <= pc + 1'b1;
            end
            if (capture) begin
                hold_valid <= 1'b1;
            end else if (hold_valid && f_ready) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk) begin
        if (imem_req) begin
            pend_addr <= pc;
        end
        if (capture) begin
            hold_addr  <= pend_addr;
            hold_instr <= imem_data;
        end
    end

endmodule

// ==== hw/ifront_pkg.sv ====
`include "ifront_settings.svh"

package ifront_pkg;

    typedef logic [`IFRONT_DATA_W-1:0] instr_t;
    typedef logic [`IFRONT_ADDR_W-1:0] addr_t;

    typedef logic [`IFRONT_TGT_HI-`IFRONT_TGT_LO:0] reg_idx_t;
    typedef logic [`IFRONT_TGT_HI-`IFRONT_TGT_LO:0] cc_t;      // same bits as the target

    typedef logic [`IFRONT_IMM_HI-`IFRONT_IMM_LO:0] imm_t;     // as it sits in the word
    typedef logic [`IFRONT_DATA_W-1:0] word_t;                 // after extension

    // ------------------------------------------------------------
    // opcodes, codes above LUI are undefined
    // ------------------------------------------------------------
    typedef enum logic [`IFRONT_OPC_HI-`IFRONT_OPC_LO:0] {
        NOP   = 0,
        MOV   = 1,   // register forms run from MOV to ST
        ADD   = 2,
        SUB   = 3,
        AND   = 4,
        OR    = 5,
        XOR   = 6,
        SHL   = 7,
        SHR   = 8,
        CMP   = 9,
        LD    = 10,
        ST    = 11,
        MOVI  = 12,  // immediate forms
        ADDI  = 13,
        SUBI  = 14,
        ADDIS = 15,
        CMPI  = 16,
        CMPIS = 17,
        STI   = 18,
        JCC   = 19,  // branches
        BCCIS = 20,
        LUI   = 21
    } opc_t;

    typedef enum logic [1:0] {
        EMPTY,
        PARTIAL,
        FULL
    } q_state_e;

    typedef enum logic {
        IDLE,
        RUN
    } fetch_state_e;

endpackage

// ==== hw/ifront_top.sv ====
`timescale 1ns/1ps

module ifront_top (
    input  logic                 iw_clk,
    input  logic                 iw_rst,
    output logic                 imem_req,
    output ifront_pkg::addr_t    imem_addr,
    input  ifront_pkg::instr_t   imem_data,
    input  logic                 redirect,
    input  ifront_pkg::addr_t    redirect_pc,
    output logic                 dec_valid,
    input  logic                 dec_ready,
    output ifront_pkg::addr_t    dec_pc,
    output ifront_pkg::instr_t   dec_instr,
    output ifront_pkg::opc_t     dec_opc,
    output logic                 dec_sgn_en,
    output logic                 dec_imm_en,
    output ifront_pkg::word_t    dec_imm_val,
    output ifront_pkg::cc_t      dec_cc,
    output ifront_pkg::reg_idx_t dec_tgt,
    output logic                 dec_tgt_we,
    output ifront_pkg::reg_idx_t dec_src,
    output logic                 dec_illegal
);
    logic               f_valid;
    logic               f_ready;
    ifront_pkg::addr_t  f_addr;
    ifront_pkg::instr_t f_instr;
    logic               q_valid;
    logic               q_ready;
    ifront_pkg::addr_t  q_addr;
    ifront_pkg::instr_t q_instr;

    // ------------------------------------------------------------
    // fetch, then buffer, then decode
    // ------------------------------------------------------------
    fetch_unit fetch0 (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .f_valid     (f_valid),
        .f_ready     (f_ready),
        .f_addr      (f_addr),
        .f_instr     (f_instr)
    );

    instr_queue queue0 (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .flush   (redirect),  // a taken branch drops everything buffered
        .f_valid (f_valid),
        .f_ready (f_ready),
        .f_addr  (f_addr),
        .f_instr (f_instr),
        .q_valid (q_valid),
        .q_ready (q_ready),
        .q_addr  (q_addr),
        .q_instr (q_instr)
    );

    decode_stage decode0 (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .flush       (redirect),
        .q_valid     (q_valid),
        .q_ready     (q_ready),
        .q_addr      (q_addr),
        .q_instr     (q_instr),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_pc      (dec_pc),
        .dec_instr   (dec_instr),
        .dec_opc     (dec_opc),
        .dec_sgn_en  (dec_sgn_en),
        .dec_imm_en  (dec_imm_en),
        .dec_imm_val (dec_imm_val),
        .dec_cc      (dec_cc),
        .dec_tgt     (dec_tgt),
        .dec_tgt_we  (dec_tgt_we),
        .dec_src     (dec_src),
        .dec_illegal (dec_illegal)
    );

endmodule

// ==== hw/instr_queue.sv ====
`timescale 1ns/1ps

`include "ifront_settings.svh"

module instr_queue (
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic               flush,
    input  logic               f_valid,
    output logic               f_ready,
    input  ifront_pkg::addr_t  f_addr,
    input  ifront_pkg::instr_t f_instr,
    output logic               q_valid,
    input  logic               q_ready,
    output ifront_pkg::addr_t  q_addr,
    output ifront_pkg::instr_t q_instr
);
    localparam int DEPTH = `IFRONT_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    ifront_pkg::addr_t    addr_mem  [DEPTH];
    ifront_pkg::instr_t   instr_mem [DEPTH];

    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr_inc;
    logic [PTR_W-1:0]     rd_ptr_inc;
    ifront_pkg::q_state_e state;
    logic                 wr_en;
    logic                 rd_en;

    assign f_ready = (state != ifront_pkg::FULL);
    assign q_valid = (state != ifront_pkg::EMPTY);
    assign q_addr  = addr_mem[rd_ptr];
    assign q_instr = instr_mem[rd_ptr];

    assign wr_en = f_valid && f_ready;
    assign rd_en = q_valid && q_ready;

    assign wr_ptr_inc = wr_ptr + 1'b1;  // wraps at DEPTH
    assign rd_ptr_inc = rd_ptr + 1'b1;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            state  <= ifront_pkg::EMPTY;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            state  <= ifront_pkg::EMPTY;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr_inc;
            end
            case ({wr_en, rd_en})
                2'b10: begin
                    state <= (wr_ptr_inc == rd_ptr) ? ifront_pkg::FULL : ifront_pkg::PARTIAL;
                end
                2'b01: begin
                    state <= (rd_ptr_inc == wr_ptr) ? ifront_pkg::EMPTY : ifront_pkg::PARTIAL;
                end
                default: begin
                    state <= state;  // a read with a write leaves the count alone
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    always_ff @(posedge iw_clk) begin
        if (wr_en) begin
            addr_mem[wr_ptr]  <= f_addr;
            instr_mem[wr_ptr] <= f_instr;
        end
    end

endmodule

// ==== ifront.f ====
+incdir+include
+incdir+dv
hw/ifront_pkg.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/decode_stage.sv
hw/ifront_top.sv
dv/ifront_tb.sv

// ==== include/ifront_settings.svh ====
`ifndef IFRONT_SETTINGS_SVH
`define IFRONT_SETTINGS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------

`define IFRONT_DATA_W       16  // one instruction word
`define IFRONT_ADDR_W       12  // word address, the pc steps by one

// ------------------------------------------------------------
// instruction fields
// ------------------------------------------------------------

`define IFRONT_OPC_HI       15
`define IFRONT_OPC_LO       11

`define IFRONT_TGT_HI       10  // branches read their condition code here
`define IFRONT_TGT_LO       8

`define IFRONT_SRC_HI       7
`define IFRONT_SRC_LO       5

`define IFRONT_IMM_HI       7   // overlaps the source field
`define IFRONT_IMM_LO       0

// ------------------------------------------------------------
// buffering
// ------------------------------------------------------------

// power of two, at least 2 so the pointers have a bit to wrap
`define IFRONT_QUEUE_DEPTH  4

`endif
